//--- tail_pkg.sv
`default_nettype none

package tail_pkg;

    // switch inputs, already synchronous to clk
    typedef struct packed {
        logic left;
        logic right;
        logic haz;
    } turn_req_t;

    // lamp order is outer left to outer right
    typedef struct packed {
        logic lc;
        logic lb;
        logic la;
        logic ra;
        logic rb;
        logic rc;
    } lamps_t;

    // each show state lasts one cycle, its wait state holds until the timer tick
    typedef enum logic [4:0] {
        idle,
        haz_on,
        haz_off,
        wait_haz_on,
        wait_haz_off,
        l0,
        l1,
        l2,
        l_off,
        wait_l0,
        wait_l1,
        wait_l2,
        wait_l_off,
        r0,
        r1,
        r2,
        r_off,
        wait_r0,
        wait_r1,
        wait_r2,
        wait_r_off
    } tail_state_t;

    // board values for a 100 MHz clock
    localparam logic [25:0] HAZ_TICKS_DEFAULT  = 26'd50_000_000;
    localparam logic [24:0] TURN_TICKS_DEFAULT = 25'd25_000_000;

endpackage

`default_nettype wire

//--- display_pkg.sv
`default_nettype none

package display_pkg;

    localparam int NUM_DIGITS = 8;

    typedef logic [$clog2(NUM_DIGITS)-1:0] digit_idx_t;

    // active low, bit i drives digit i
    typedef logic [NUM_DIGITS-1:0] anodes_t;

    // active low, segment a in the msb down to g in the lsb
    typedef logic [6:0] seg_t;

    // three horizontal bars, reads as a lit lamp
    localparam seg_t SEG_LIT   = 7'b0110110;
    localparam seg_t SEG_BLANK = 7'b1111111;

    // about 1 ms per digit at 100 MHz
    localparam int unsigned SCAN_TICKS_DEFAULT = 99_999;

endpackage

`default_nettype wire

//--- tick_timer.sv
`default_nettype none

module tick_timer #(
    parameter int unsigned PERIOD = 1
) (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    output logic tick
);

    localparam int unsigned CNT_W = $clog2(PERIOD + 1);
    localparam logic [CNT_W-1:0] TOP = CNT_W'(PERIOD);

    logic [CNT_W-1:0] count;

    if (PERIOD < 1) begin : g_bad_period
        $error("tick_timer needs PERIOD of 1 or more");
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear || count == TOP) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // one pulse per PERIOD+1 cycles while running
    assign tick = (count == TOP);

    a_count_in_range: assert property (
        @(posedge clk) disable iff (reset) count <= TOP
    );

endmodule

`default_nettype wire

//--- tail_light_fsm.sv
`default_nettype none

module tail_light_fsm #(
    parameter int unsigned HAZ_TICKS  = tail_pkg::HAZ_TICKS_DEFAULT,
    parameter int unsigned TURN_TICKS = tail_pkg::TURN_TICKS_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,
    input  tail_pkg::turn_req_t req,
    output tail_pkg::lamps_t    lamps
);

    import tail_pkg::*;

    tail_state_t state;
    tail_state_t state_next;

    logic haz_clear;
    logic haz_tick;
    logic turn_clear;
    logic turn_tick;
    logic left_only;
    logic right_only;

    tick_timer #(
        .PERIOD(HAZ_TICKS)
    ) u_haz_timer (
        .clk  (clk),
        .reset(reset),
        .clear(haz_clear),
        .tick (haz_tick)
    );

    tick_timer #(
        .PERIOD(TURN_TICKS)
    ) u_turn_timer (
        .clk  (clk),
        .reset(reset),
        .clear(turn_clear),
        .tick (turn_tick)
    );

    // hazard wins over any turn request
    assign left_only  = req.left & ~req.right & ~req.haz;
    assign right_only = req.right & ~req.left & ~req.haz;

    // timers only run in their own wait states
    assign haz_clear  = !(state inside {wait_haz_on, wait_haz_off});
    assign turn_clear = !(state inside {wait_l0, wait_l1, wait_l2, wait_l_off,
                                        wait_r0, wait_r1, wait_r2, wait_r_off});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            idle: begin
                if (req.haz)
                    state_next = haz_on;
                else if (left_only)
                    state_next = l0;
                else if (right_only)
                    state_next = r0;
                else
                    state_next = idle;
            end

            haz_on:       state_next = req.haz ? wait_haz_on : idle;
            haz_off:      state_next = req.haz ? wait_haz_off : idle;
            wait_haz_on:  state_next = !req.haz ? idle : (haz_tick ? haz_off : wait_haz_on);
            wait_haz_off: state_next = !req.haz ? idle : (haz_tick ? haz_on : wait_haz_off);

            // left sweep
            l0:         state_next = left_only ? wait_l0 : idle;
            l1:         state_next = left_only ? wait_l1 : idle;
            l2:         state_next = left_only ? wait_l2 : idle;
            l_off:      state_next = left_only ? wait_l_off : idle;
            wait_l0:    state_next = !left_only ? idle : (turn_tick ? l1 : wait_l0);
            wait_l1:    state_next = !left_only ? idle : (turn_tick ? l2 : wait_l1);
            wait_l2:    state_next = !left_only ? idle : (turn_tick ? l_off : wait_l2);
            wait_l_off: state_next = !left_only ? idle : (turn_tick ? l0 : wait_l_off);

            // right sweep
            r0:         state_next = right_only ? wait_r0 : idle;
            r1:         state_next = right_only ? wait_r1 : idle;
            r2:         state_next = right_only ? wait_r2 : idle;
            r_off:      state_next = right_only ? wait_r_off : idle;
            wait_r0:    state_next = !right_only ? idle : (turn_tick ? r1 : wait_r0);
            wait_r1:    state_next = !right_only ? idle : (turn_tick ? r2 : wait_r1);
            wait_r2:    state_next = !right_only ? idle : (turn_tick ? r_off : wait_r2);
            wait_r_off: state_next = !right_only ? idle : (turn_tick ? r0 : wait_r_off);

            default:    state_next = idle;
        endcase
    end

    // lamps depend on the state only, so a show state and its wait look the same
    always_comb begin
        case (state)
            haz_on, wait_haz_on: lamps = lamps_t'(6'b111_111);
            l0, wait_l0:         lamps = lamps_t'(6'b001_000);
            l1, wait_l1:         lamps = lamps_t'(6'b011_000);
            l2, wait_l2:         lamps = lamps_t'(6'b111_000);
            r0, wait_r0:         lamps = lamps_t'(6'b000_100);
            r1, wait_r1:         lamps = lamps_t'(6'b000_110);
            r2, wait_r2:         lamps = lamps_t'(6'b000_111);
            default:             lamps = lamps_t'(6'b000_000);
        endcase
    end

    // a sweep never lights the other side, only hazard lights both
    a_sides_only_in_hazard: assert property (
        @(posedge clk) disable iff (reset)
        ((lamps.lc | lamps.lb | lamps.la) && (lamps.ra | lamps.rb | lamps.rc))
            |-> (lamps == lamps_t'(6'b111_111))
    );

    a_dark_after_reset: assert property (
        @(posedge clk) reset |=> (lamps == lamps_t'(6'b000_000))
    );

endmodule

`default_nettype wire

//--- display_scan.sv
`default_nettype none

module display_scan #(
    parameter int unsigned SCAN_TICKS = display_pkg::SCAN_TICKS_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  tail_pkg::lamps_t     lamps,
    output display_pkg::anodes_t anodes,
    output display_pkg::seg_t    seg
);

    import display_pkg::*;

    logic       scan_tick;
    digit_idx_t digit;
    logic       lamp_sel;

    // free running, never cleared
    tick_timer #(
        .PERIOD(SCAN_TICKS)
    ) u_scan_timer (
        .clk  (clk),
        .reset(reset),
        .clear(1'b0),
        .tick (scan_tick)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            digit <= '0;
        end else if (scan_tick) begin
            if (digit == digit_idx_t'(NUM_DIGITS - 1))
                digit <= '0;
            else
                digit <= digit + 1'b1;
        end
    end

    // one digit enabled at a time
    assign anodes = ~(anodes_t'(1) << digit);

    // left lamps on digits 7..5, right lamps on 2..0
    always_comb begin
        case (digit)
            3'd0:    lamp_sel = lamps.rc;
            3'd1:    lamp_sel = lamps.rb;
            3'd2:    lamp_sel = lamps.ra;
            3'd5:    lamp_sel = lamps.la;
            3'd6:    lamp_sel = lamps.lb;
            3'd7:    lamp_sel = lamps.lc;
            // the gap between the two sides
            default: lamp_sel = 1'b0;
        endcase
    end

    assign seg = lamp_sel ? SEG_LIT : SEG_BLANK;

    a_one_anode: assert property (
        @(posedge clk) disable iff (reset) $onehot(~anodes)
    );

endmodule

`default_nettype wire

//--- tail_light_top.sv
`default_nettype none

module tail_light_top #(
    parameter int unsigned HAZ_TICKS  = tail_pkg::HAZ_TICKS_DEFAULT,
    parameter int unsigned TURN_TICKS = tail_pkg::TURN_TICKS_DEFAULT,
    parameter int unsigned SCAN_TICKS = display_pkg::SCAN_TICKS_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  tail_pkg::turn_req_t  req,
    output tail_pkg::lamps_t     lamps,
    output display_pkg::anodes_t anodes,
    output display_pkg::seg_t    seg
);

    // lamp controller, also drives the led outputs
    tail_light_fsm #(
        .HAZ_TICKS (HAZ_TICKS),
        .TURN_TICKS(TURN_TICKS)
    ) u_fsm (
        .clk  (clk),
        .reset(reset),
        .req  (req),
        .lamps(lamps)
    );

    // mirrors the lamps onto the seven-segment digits
    display_scan #(
        .SCAN_TICKS(SCAN_TICKS)
    ) u_scan (
        .clk   (clk),
        .reset (reset),
        .lamps (lamps),
        .anodes(anodes),
        .seg   (seg)
    );

endmodule

`default_nettype wire

//--- tb_tail_light.sv
`default_nettype none

module tb_tail_light;

    import tail_pkg::*;
    import display_pkg::*;

    localparam int unsigned HAZ_TICKS  = 6;
    localparam int unsigned TURN_TICKS = 4;
    localparam int unsigned SCAN_TICKS = 2;
    localparam logic [31:0] SEED       = 32'he448_8580;

    typedef enum {mode_idle, mode_haz, mode_left, mode_right} mode_t;

    logic      clk;
    logic      reset;
    turn_req_t req;
    lamps_t    lamps;
    anodes_t   anodes;
    seg_t      seg;

    logic [31:0] rng;
    int          errors;
    int          timeouts;
    int          cycles;

    // model of the DUT that advances from the request only
    mode_t   run_mode;
    int      step_n;
    int      exp_digit;
    int      scan_cnt;
    lamps_t  exp_lamps;
    anodes_t exp_anodes;
    seg_t    exp_seg;

    tail_light_top #(
        .HAZ_TICKS (HAZ_TICKS),
        .TURN_TICKS(TURN_TICKS),
        .SCAN_TICKS(SCAN_TICKS)
    ) u_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .lamps (lamps),
        .anodes(anodes),
        .seg   (seg)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mode_t requested_mode(input turn_req_t r);
        if (r.haz)
            return mode_haz;
        if (r.left && !r.right)
            return mode_left;
        if (r.right && !r.left)
            return mode_right;
        return mode_idle;
    endfunction

    // n counts cycles since the mode's first pattern appeared
    function automatic lamps_t expected_lamps(input mode_t mode, input int n);
        lamps_t l;
        int     s;
        l = '0;
        if (mode == mode_haz) begin
            if ((n / (HAZ_TICKS + 2)) % 2 == 0)
                l = '1;
        end else if (mode != mode_idle) begin
            s = (n / (TURN_TICKS + 2)) % 4;
            // inner, then inner and middle, then all three, then dark
            if (mode == mode_left) begin
                l.la = (s != 3);
                l.lb = (s == 1 || s == 2);
                l.lc = (s == 2);
            end else begin
                l.ra = (s != 3);
                l.rb = (s == 1 || s == 2);
                l.rc = (s == 2);
            end
        end
        return l;
    endfunction

    // only the scanned digit has its anode low
    function automatic anodes_t expected_anodes(input int digit);
        anodes_t a;
        a        = '1;
        a[digit] = 1'b0;
        return a;
    endfunction

    function automatic seg_t expected_seg(input int digit, input lamps_t l);
        logic lit;
        case (digit)
            0:       lit = l.rc;
            1:       lit = l.rb;
            2:       lit = l.ra;
            5:       lit = l.la;
            6:       lit = l.lb;
            7:       lit = l.lc;
            default: lit = 1'b0;
        endcase
        return lit ? SEG_LIT : SEG_BLANK;
    endfunction

    // compare in the middle of the cycle, then step the model to the next edge
    always @(negedge clk) begin
        if (reset) begin
            run_mode  = mode_idle;
            step_n    = 0;
            exp_digit = 0;
            scan_cnt  = 0;
        end else begin
            exp_lamps  = expected_lamps(run_mode, step_n);
            exp_anodes = expected_anodes(exp_digit);
            exp_seg    = expected_seg(exp_digit, exp_lamps);
            cycles++;
            assert (lamps === exp_lamps) else begin
                errors++;
                $display("** Error at %0t: lamps expected %b, got %b", $time, exp_lamps, lamps);
            end
            assert (anodes === exp_anodes) else begin
                errors++;
                $display("** Error at %0t: anodes expected %b, got %b",
                         $time, exp_anodes, anodes);
            end
            assert (seg === exp_seg) else begin
                errors++;
                $display("** Error at %0t: seg expected %b, got %b", $time, exp_seg, seg);
            end
            if (run_mode == mode_idle) begin
                if (requested_mode(req) != mode_idle) begin
                    run_mode = requested_mode(req);
                    step_n   = 0;
                end
            end else if (requested_mode(req) != run_mode) begin
                run_mode = mode_idle;
                step_n   = 0;
            end else begin
                step_n++;
            end
            if (scan_cnt == SCAN_TICKS) begin
                scan_cnt  = 0;
                exp_digit = (exp_digit + 1) % NUM_DIGITS;
            end else begin
                scan_cnt++;
            end
        end
    end

    task automatic drive_req(input logic l, input logic r, input logic h);
        @(posedge clk);
        req <= {l, r, h};
    endtask

    task automatic hold_random(input int base, input int span);
        int n;
        rng = xorshift32(rng);
        n = base + int'(rng % 32'(span));
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_lamp_change(input int limit);
        lamps_t start;
        int     i;
        @(negedge clk);
        start = lamps;
        for (i = 0; i < limit && lamps === start; i++)
            @(negedge clk);
        assert (lamps !== start) else begin
            errors++;
            timeouts++;
            $display("timeout at %0t: lamps did not change within %0d cycles", $time, limit);
        end
    endtask

    task automatic wait_for_digit(input int digit, input int limit);
        int i;
        for (i = 0; i < limit && anodes !== expected_anodes(digit); i++)
            @(negedge clk);
        assert (anodes === expected_anodes(digit)) else begin
            errors++;
            timeouts++;
            $display("timeout at %0t: digit %0d was not scanned within %0d cycles",
                     $time, digit, limit);
        end
    endtask

    initial begin
        req      = '0;
        reset    = 1'b1;
        rng      = SEED;
        errors   = 0;
        timeouts = 0;
        cycles   = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // one full pass over the digits while dark
        wait_for_digit(7, 40);
        wait_for_digit(0, 10);

        // two sweeps or more on each side
        drive_req(1'b1, 1'b0, 1'b0);
        wait_lamp_change(10);
        hold_random(8 * (TURN_TICKS + 2), 8);
        drive_req(1'b0, 1'b0, 1'b0);
        hold_random(3, 6);
        drive_req(1'b0, 1'b1, 1'b0);
        wait_lamp_change(10);
        hold_random(8 * (TURN_TICKS + 2), 8);

        // both turn switches ends the sweep
        drive_req(1'b1, 1'b1, 1'b0);
        hold_random(4, 6);

        // hazard arrives in the middle of a left sweep
        drive_req(1'b1, 1'b0, 1'b0);
        wait_lamp_change(10);
        hold_random(8, 10);
        drive_req(1'b1, 1'b0, 1'b1);
        wait_lamp_change(10);
        repeat (20) begin
            rng = xorshift32(rng);
            drive_req(rng[3], rng[7], 1'b1);
            hold_random(1, 4);
        end

        drive_req(1'b0, 1'b0, 1'b0);
        hold_random(4, 6);
        drive_req(1'b1, 1'b1, 1'b0);
        hold_random(10, 4);
        drive_req(1'b0, 1'b0, 1'b0);
        repeat (5) @(posedge clk);
        @(negedge clk);

        $display("%0d cycles checked, %0d errors, %0d timeouts", cycles, errors, timeouts);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
tail_pkg.sv
display_pkg.sv
tick_timer.sv
tail_light_fsm.sv
display_scan.sv
tail_light_top.sv
tb_tail_light.sv

//--- Makefile
# Verilator build for the tail light controller

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_tail_light
RTL_TOP   ?= tail_light_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
